/* hw/cr16Pkg.sv */
package cr16Pkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int opWidth = 4;
	localparam int immWidth = 8;
	localparam int flagWidth = 5;

	// opcode field, zero selects the register form.
	localparam logic [opWidth-1:0] opReg = 4'b0000;
	localparam logic [opWidth-1:0] opAndi = 4'b0001;
	localparam logic [opWidth-1:0] opOri = 4'b0010;
	localparam logic [opWidth-1:0] opXori = 4'b0011;
	localparam logic [opWidth-1:0] opAddi = 4'b0101;
	localparam logic [opWidth-1:0] opSubi = 4'b1001;
	localparam logic [opWidth-1:0] opCmpi = 4'b1011;
	localparam logic [opWidth-1:0] opMovi = 4'b1101;

	// function field of the register form.
	localparam logic [opWidth-1:0] fnNone = 4'b0000; // no operation, no write.
	localparam logic [opWidth-1:0] fnAnd = 4'b0001;
	localparam logic [opWidth-1:0] fnOr = 4'b0010;
	localparam logic [opWidth-1:0] fnXor = 4'b0011;
	localparam logic [opWidth-1:0] fnLsh = 4'b0100;
	localparam logic [opWidth-1:0] fnAdd = 4'b0101;
	localparam logic [opWidth-1:0] fnAddu = 4'b0110;
	localparam logic [opWidth-1:0] fnAshu = 4'b1000;
	localparam logic [opWidth-1:0] fnSub = 4'b1001;
	localparam logic [opWidth-1:0] fnCmp = 4'b1011;
	localparam logic [opWidth-1:0] fnMov = 4'b1101;
	localparam logic [opWidth-1:0] fnNot = 4'b1111;

	// bit positions in the flag word.
	localparam int flagC = 0; // carry or borrow.
	localparam int flagF = 1; // signed overflow.
	localparam int flagL = 2; // unsigned lower.
	localparam int flagZ = 3; // equal.
	localparam int flagN = 4; // signed lower.

	typedef union packed {
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regAddrWidth-1:0] dst;
			logic [opWidth-1:0] func;
			logic [regAddrWidth-1:0] src;
		} regForm;
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regAddrWidth-1:0] dst;
			logic [immWidth-1:0] imm;
		} immForm;
	} instWord_u;

endpackage

/* hw/instQueue.sv */
`timescale 1ns/1ps

module instQueue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input cr16Pkg::instWord_u instData,
	input logic pop,
	output logic headValid,
	output cr16Pkg::instWord_u headInst,
	output logic instCredit
);
	import cr16Pkg::*;

	localparam int ptrWidth = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int countWidth = $clog2(QUEUE_DEPTH + 1);

	instWord_u entries [QUEUE_DEPTH];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] occupancy;
	logic doPop;

	// wraps at the depth, which need not be a power of two.
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign doPop = pop && headValid; // never pop an empty queue.
	assign headValid = (occupancy != '0);
	assign headInst = entries[rdPtr];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			occupancy <= '0;
			instCredit <= 1'b0;
		end else begin
			if (instValid)
				wrPtr <= nextPtr(wrPtr); // space guaranteed by the producer's credits.
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({instValid, doPop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: ;
			endcase
			instCredit <= doPop; // one credit back per freed entry.
		end
	end

	always_ff @(posedge clk) begin
		if (instValid)
			entries[wrPtr] <= instData;
	end

endmodule

/* hw/registerFile.sv */
`timescale 1ns/1ps

module registerFile #(
	parameter int NUM_REGS = 16
) (
	input logic clk,
	input logic rstN,
	input logic writeEn,
	input logic [cr16Pkg::regAddrWidth-1:0] writeAddr,
	input logic [cr16Pkg::dataWidth-1:0] writeData,
	input logic [cr16Pkg::regAddrWidth-1:0] srcAddr,
	input logic [cr16Pkg::regAddrWidth-1:0] dstAddr,
	output logic [cr16Pkg::dataWidth-1:0] readData1,
	output logic [cr16Pkg::dataWidth-1:0] readData2
);
	import cr16Pkg::*;

	logic [dataWidth-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0; // all registers start at zero.
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// combinational reads, a write shows on the next cycle.
	assign readData1 = regs[srcAddr];
	assign readData2 = regs[dstAddr];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic [cr16Pkg::opWidth-1:0] aluFunc,
	input logic [cr16Pkg::dataWidth-1:0] aluIn1,
	input logic [cr16Pkg::dataWidth-1:0] aluIn2,
	output logic [cr16Pkg::dataWidth-1:0] aluOut,
	output logic [cr16Pkg::flagWidth-1:0] aluFlags,
	output logic [cr16Pkg::flagWidth-1:0] flagMask,
	output logic writesReg
);
	import cr16Pkg::*;

	logic [dataWidth:0] sum;
	logic [dataWidth:0] diff;
	logic [4:0] shiftAmt;
	logic [4:0] rightAmt;
	logic shiftLeft;
	logic addOverflow;
	logic subOverflow;

	assign sum = {1'b0, aluIn1} + {1'b0, aluIn2};
	assign diff = {1'b0, aluIn1} - {1'b0, aluIn2}; // msb is the borrow.

	// signs equal in, sign differs out.
	assign addOverflow = (aluIn1[dataWidth-1] == aluIn2[dataWidth-1])
		&& (sum[dataWidth-1] != aluIn1[dataWidth-1]);
	assign subOverflow = (aluIn1[dataWidth-1] != aluIn2[dataWidth-1])
		&& (diff[dataWidth-1] != aluIn1[dataWidth-1]);

	// signed amount, negative shifts right.
	assign shiftAmt = aluIn2[4:0];
	assign shiftLeft = !shiftAmt[4];
	assign rightAmt = -shiftAmt; // -16 gives 16.

	always_comb begin
		aluOut = '0;
		aluFlags = '0;
		flagMask = '0;
		writesReg = 1'b1;
		case (aluFunc)
			fnAnd: aluOut = aluIn1 & aluIn2;
			fnOr: aluOut = aluIn1 | aluIn2;
			fnXor: aluOut = aluIn1 ^ aluIn2;
			fnNot: aluOut = ~aluIn1;
			fnMov: aluOut = aluIn2;
			fnAdd: begin
				aluOut = sum[dataWidth-1:0];
				aluFlags[flagC] = sum[dataWidth];
				aluFlags[flagF] = addOverflow;
				flagMask[flagC] = 1'b1;
				flagMask[flagF] = 1'b1;
			end
			fnAddu: begin
				aluOut = sum[dataWidth-1:0];
				aluFlags[flagC] = sum[dataWidth];
				flagMask[flagC] = 1'b1;
			end
			fnSub: begin
				aluOut = diff[dataWidth-1:0];
				aluFlags[flagC] = diff[dataWidth];
				aluFlags[flagF] = subOverflow;
				flagMask[flagC] = 1'b1;
				flagMask[flagF] = 1'b1;
			end
			fnCmp: begin
				aluOut = diff[dataWidth-1:0];
				aluFlags[flagZ] = (aluIn1 == aluIn2);
				aluFlags[flagL] = (aluIn1 < aluIn2); // unsigned.
				aluFlags[flagN] = ($signed(aluIn1) < $signed(aluIn2));
				flagMask[flagZ] = 1'b1;
				flagMask[flagL] = 1'b1;
				flagMask[flagN] = 1'b1;
				writesReg = 1'b0; // compare leaves registers alone.
			end
			fnLsh: begin
				if (shiftLeft)
					aluOut = aluIn1 << shiftAmt[3:0];
				else
					aluOut = aluIn1 >> rightAmt; // zero fill.
			end
			fnAshu: begin
				if (shiftLeft)
					aluOut = aluIn1 << shiftAmt[3:0];
				else
					aluOut = $signed(aluIn1) >>> rightAmt; // sign fill.
			end
			default: writesReg = 1'b0; // unknown function does nothing.
		endcase
	end

endmodule

/* hw/issueControl.sv */
`timescale 1ns/1ps

module issueControl #(
	parameter int RESULT_CREDITS = 2
) (
	input logic clk,
	input logic rstN,
	input logic headValid,
	input cr16Pkg::instWord_u headInst,
	output logic pop,
	output logic [cr16Pkg::regAddrWidth-1:0] srcAddr,
	output logic [cr16Pkg::regAddrWidth-1:0] dstAddr,
	input logic [cr16Pkg::dataWidth-1:0] readData1,
	input logic [cr16Pkg::dataWidth-1:0] readData2,
	output logic [cr16Pkg::opWidth-1:0] aluFunc,
	output logic [cr16Pkg::dataWidth-1:0] aluIn1,
	output logic [cr16Pkg::dataWidth-1:0] aluIn2,
	input logic [cr16Pkg::dataWidth-1:0] aluOut,
	input logic [cr16Pkg::flagWidth-1:0] aluFlags,
	input logic [cr16Pkg::flagWidth-1:0] flagMask,
	input logic writesReg,
	output logic writeEn,
	output logic [cr16Pkg::regAddrWidth-1:0] writeAddr,
	output logic [cr16Pkg::dataWidth-1:0] writeData,
	input logic resultCredit,
	output logic resultValid,
	output logic [cr16Pkg::dataWidth-1:0] resultData,
	output logic [cr16Pkg::flagWidth-1:0] resultFlags
);
	import cr16Pkg::*;

	localparam int creditWidth = $clog2(RESULT_CREDITS + 1);

	logic [creditWidth-1:0] creditCount;
	logic [flagWidth-1:0] statusFlags;
	logic [dataWidth-1:0] immExt;
	logic isImm;
	logic fire;

	assign isImm = (headInst.regForm.opcode != opReg);
	assign immExt = {{(dataWidth - immWidth){headInst.immForm.imm[immWidth-1]}},
		headInst.immForm.imm};

	// both forms share the destination field.
	assign dstAddr = headInst.regForm.dst;
	assign srcAddr = headInst.regForm.src;

	// immediate opcodes mapped onto their register functions.
	always_comb begin
		aluFunc = fnNone;
		case (headInst.regForm.opcode)
			opReg: aluFunc = headInst.regForm.func;
			opAndi: aluFunc = fnAnd;
			opOri: aluFunc = fnOr;
			opXori: aluFunc = fnXor;
			opAddi: aluFunc = fnAdd;
			opSubi: aluFunc = fnSub;
			opCmpi: aluFunc = fnCmp;
			opMovi: aluFunc = fnMov;
			default: ;
		endcase
	end

	assign aluIn1 = readData2; // destination register.
	assign aluIn2 = isImm ? immExt : readData1;

	assign fire = headValid && (creditCount != '0);
	assign pop = fire;

	assign writeEn = fire && writesReg;
	assign writeAddr = dstAddr;
	assign writeData = aluOut;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			creditCount <= creditWidth'(RESULT_CREDITS);
			statusFlags <= '0;
			resultValid <= 1'b0;
		end else begin
			// one spent per issue, one back per returned credit.
			creditCount <= creditCount + creditWidth'(resultCredit) - creditWidth'(fire);
			resultValid <= fire;
			if (fire)
				statusFlags <= (statusFlags & ~flagMask) | (aluFlags & flagMask);
		end
	end

	// compare beats carry the first operand.
	always_ff @(posedge clk) begin
		if (fire)
			resultData <= writesReg ? aluOut : aluIn1;
	end

	assign resultFlags = statusFlags; // flags as left by the beat.

endmodule

/* hw/cr16Datapath.sv */
`timescale 1ns/1ps

module cr16Datapath #(
	parameter int QUEUE_DEPTH = 4,
	parameter int RESULT_CREDITS = 2,
	parameter int NUM_REGS = 16
) (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input cr16Pkg::instWord_u instData,
	output logic instCredit,
	input logic resultCredit,
	output logic resultValid,
	output logic [cr16Pkg::dataWidth-1:0] resultData,
	output logic [cr16Pkg::flagWidth-1:0] resultFlags
);
	import cr16Pkg::*;

	logic headValid;
	instWord_u headInst;
	logic pop;
	logic [regAddrWidth-1:0] srcAddr;
	logic [regAddrWidth-1:0] dstAddr;
	logic [dataWidth-1:0] readData1;
	logic [dataWidth-1:0] readData2;
	logic [opWidth-1:0] aluFunc;
	logic [dataWidth-1:0] aluIn1;
	logic [dataWidth-1:0] aluIn2;
	logic [dataWidth-1:0] aluOut;
	logic [flagWidth-1:0] aluFlags;
	logic [flagWidth-1:0] flagMask;
	logic writesReg;
	logic writeEn;
	logic [regAddrWidth-1:0] writeAddr;
	logic [dataWidth-1:0] writeData;

	instQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instData(instData),
		.pop(pop),
		.headValid(headValid),
		.headInst(headInst),
		.instCredit(instCredit)
	);

	issueControl #(
		.RESULT_CREDITS(RESULT_CREDITS)
	) issue (
		.clk(clk),
		.rstN(rstN),
		.headValid(headValid),
		.headInst(headInst),
		.pop(pop),
		.srcAddr(srcAddr),
		.dstAddr(dstAddr),
		.readData1(readData1),
		.readData2(readData2),
		.aluFunc(aluFunc),
		.aluIn1(aluIn1),
		.aluIn2(aluIn2),
		.aluOut(aluOut),
		.aluFlags(aluFlags),
		.flagMask(flagMask),
		.writesReg(writesReg),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultFlags(resultFlags)
	);

	registerFile #(
		.NUM_REGS(NUM_REGS)
	) regFile (
		.clk(clk),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.srcAddr(srcAddr),
		.dstAddr(dstAddr),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu aluUnit (
		.aluFunc(aluFunc),
		.aluIn1(aluIn1),
		.aluIn2(aluIn2),
		.aluOut(aluOut),
		.aluFlags(aluFlags),
		.flagMask(flagMask),
		.writesReg(writesReg)
	);

endmodule

/* verification/cr16Datapath_assertions.sv */
`timescale 1ns/1ps

module cr16DatapathAssertions #(
	parameter int QUEUE_DEPTH = 4,
	parameter int RESULT_CREDITS = 2
) (
	input logic clk,
	input logic rstN,
	input logic pop,
	input logic instCredit,
	input logic resultCredit,
	input logic resultValid,
	input logic [cr16Pkg::flagWidth-1:0] resultFlags,
	input logic [$clog2(QUEUE_DEPTH + 1)-1:0] occupancy
);
	int creditsHeld; // beats the consumer still has room for.
	int failCount = 0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			creditsHeld <= RESULT_CREDITS;
		else
			creditsHeld <= creditsHeld + int'(resultCredit) - int'(resultValid);
	end

	resetIdle: assert property (@(posedge clk)
		$rose(rstN) |-> !resultValid && !instCredit && resultFlags == '0)
		else begin
			$error("outputs not idle when reset was released");
			failCount++;
		end

	beatHasCredit: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |-> creditsHeld > 0)
		else begin
			$error("result beat sent without a returned credit");
			failCount++;
		end

	queueBound: assert property (@(posedge clk) disable iff (!rstN)
		occupancy <= QUEUE_DEPTH)
		else begin
			$error("instruction queue holds more entries than its depth");
			failCount++;
		end

	creditAfterPop: assert property (@(posedge clk) disable iff (!rstN)
		pop |=> instCredit)
		else begin
			$error("no instruction credit in the cycle after a pop");
			failCount++;
		end

	creditNeedsPop: assert property (@(posedge clk) disable iff (!rstN)
		instCredit |-> $past(pop))
		else begin
			$error("instruction credit returned without a pop before it");
			failCount++;
		end

endmodule

bind cr16Datapath cr16DatapathAssertions #(
	.QUEUE_DEPTH(QUEUE_DEPTH),
	.RESULT_CREDITS(RESULT_CREDITS)
) protocolCheck (
	.clk(clk),
	.rstN(rstN),
	.pop(pop),
	.instCredit(instCredit),
	.resultCredit(resultCredit),
	.resultValid(resultValid),
	.resultFlags(resultFlags),
	.occupancy(queue.occupancy)
);

/* verification/cr16DatapathTb.sv */
`timescale 1ns/1ps

module cr16DatapathTb;
	import cr16Pkg::*;

	localparam int queueDepth = 4;
	localparam int resultCredits = 2;
	localparam int holdCycles = 12; // consumer pause per 40 cycles.
	localparam int numDirected = 22;
	localparam int numInst = 64;
	localparam int clkPeriod = 4;
	localparam logic [opWidth-1:0] immOps [7] = '{opAndi, opOri, opXori, opAddi, opSubi,
		opCmpi, opMovi};
	localparam logic [opWidth-1:0] regFuncs [11] = '{fnAnd, fnOr, fnXor, fnNot, fnMov, fnAdd,
		fnAddu, fnSub, fnCmp, fnLsh, fnAshu};

	logic clk;
	logic rstN;
	logic instValid;
	instWord_u instData;
	logic instCredit;
	logic resultCredit;
	logic resultValid;
	logic [dataWidth-1:0] resultData;
	logic [flagWidth-1:0] resultFlags;

	instWord_u instList [numInst];
	logic [dataWidth-1:0] modelRegs [16];
	logic [flagWidth-1:0] modelFlags;
	logic [dataWidth-1:0] expDataArr [numInst];
	logic [flagWidth-1:0] expFlagsArr [numInst];
	logic [dataWidth-1:0] expData;
	logic [flagWidth-1:0] expFlags;
	int sendIdx = 0;
	int checkIdx = 0; // next beat to compare.
	int valueErrors = 0;
	int protocolErrors;
	int seed;

	cr16Datapath #(
		.QUEUE_DEPTH(queueDepth),
		.RESULT_CREDITS(resultCredits)
	) DUT (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instData(instData),
		.instCredit(instCredit),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.resultData(resultData),
		.resultFlags(resultFlags)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic instWord_u regInst(input logic [3:0] func, input logic [3:0] dst,
		input logic [3:0] src);
		instWord_u w;
		w.regForm.opcode = opReg;
		w.regForm.dst = dst;
		w.regForm.func = func;
		w.regForm.src = src;
		return w;
	endfunction

	function automatic instWord_u immInst(input logic [3:0] op, input logic [3:0] dst,
		input logic [7:0] imm);
		instWord_u w;
		w.immForm.opcode = op;
		w.immForm.dst = dst;
		w.immForm.imm = imm;
		return w;
	endfunction

	// reference model in issue order, which is send order.
	task automatic modelIssue(input instWord_u inst, output logic [dataWidth-1:0] data,
		output logic [flagWidth-1:0] flags);
		logic [opWidth-1:0] func;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] r;
		logic [flagWidth-1:0] newFlags;
		logic [flagWidth-1:0] mask;
		logic writes;
		int wide;
		int amt;
		a = modelRegs[inst.regForm.dst];
		b = modelRegs[inst.regForm.src];
		func = inst.regForm.func;
		if (inst.immForm.opcode != opReg) begin
			b = {{8{inst.immForm.imm[7]}}, inst.immForm.imm}; // sign extended.
			case (inst.immForm.opcode)
				opAndi: func = fnAnd;
				opOri: func = fnOr;
				opXori: func = fnXor;
				opAddi: func = fnAdd;
				opSubi: func = fnSub;
				opCmpi: func = fnCmp;
				default: func = fnMov;
			endcase
		end
		r = '0;
		newFlags = '0;
		mask = '0;
		writes = 1'b1;
		amt = int'($signed(b[4:0]));
		case (func)
			fnAnd: r = a & b;
			fnOr: r = a | b;
			fnXor: r = a ^ b;
			fnNot: r = ~a;
			fnMov: r = b;
			fnAdd, fnAddu: begin
				r = a + b;
				wide = int'(a) + int'(b);
				newFlags[flagC] = (wide > 65535);
				mask[flagC] = 1'b1;
				if (func == fnAdd) begin
					wide = int'($signed(a)) + int'($signed(b));
					newFlags[flagF] = (wide > 32767) || (wide < -32768);
					mask[flagF] = 1'b1;
				end
			end
			fnSub: begin
				r = a - b;
				wide = int'($signed(a)) - int'($signed(b));
				newFlags[flagC] = (a < b); // borrow.
				newFlags[flagF] = (wide > 32767) || (wide < -32768);
				mask[flagC] = 1'b1;
				mask[flagF] = 1'b1;
			end
			fnCmp: begin
				r = a; // beat shows the first operand.
				newFlags[flagZ] = (a == b);
				newFlags[flagL] = (a < b);
				newFlags[flagN] = ($signed(a) < $signed(b));
				mask[flagZ] = 1'b1;
				mask[flagL] = 1'b1;
				mask[flagN] = 1'b1;
				writes = 1'b0;
			end
			fnLsh: begin
				if (amt >= 0)
					r = a << amt;
				else
					r = a >> (-amt);
			end
			fnAshu: begin
				if (amt >= 0)
					r = a << amt;
				else
					r = $signed(a) >>> (-amt);
			end
			default: writes = 1'b0;
		endcase
		if (writes)
			modelRegs[inst.regForm.dst] = r;
		modelFlags = (modelFlags & ~mask) | (newFlags & mask);
		data = r;
		flags = modelFlags;
	endtask

	task automatic buildProgram();
		logic [31:0] kind;
		logic [31:0] dst;
		logic [31:0] src;
		instList[0] = immInst(opMovi, 1, 8'hFF);
		instList[1] = immInst(opMovi, 2, 8'hFF);
		instList[2] = regInst(fnLsh, 1, 2); // 0x7FFF.
		instList[3] = immInst(opMovi, 3, 8'h01);
		instList[4] = regInst(fnAdd, 1, 3); // signed overflow.
		instList[5] = regInst(fnMov, 7, 1);
		instList[6] = immInst(opMovi, 4, 8'hFF);
		instList[7] = immInst(opAndi, 4, 8'h00);
		instList[8] = immInst(opSubi, 5, 8'h01); // 0 - 1 borrows.
		instList[9] = regInst(fnAddu, 5, 3);
		instList[10] = regInst(fnCmp, 1, 7);
		instList[11] = immInst(opCmpi, 2, 8'h01);
		instList[12] = regInst(fnCmp, 3, 2);
		instList[13] = regInst(fnAshu, 1, 2);
		instList[14] = immInst(opMovi, 6, 8'h04);
		instList[15] = regInst(fnLsh, 3, 6);
		instList[16] = regInst(fnNot, 3, 0);
		instList[17] = regInst(fnXor, 4, 1);
		instList[18] = immInst(opOri, 6, 8'h5A);
		instList[19] = immInst(opXori, 6, 8'hFF);
		instList[20] = regInst(fnOr, 7, 3);
		instList[21] = regInst(fnLsh, 6, 2);
		for (int i = numDirected; i < numInst; i++) begin
			kind = $random(seed);
			dst = $random(seed);
			src = $random(seed);
			if (kind[0])
				instList[i] = immInst(immOps[kind[15:1] % 7], dst[3:0], src[7:0]);
			else
				instList[i] = regInst(regFuncs[kind[15:1] % 11], dst[3:0], src[3:0]);
		end
	endtask

	assign expData = expDataArr[checkIdx];
	assign expFlags = expFlagsArr[checkIdx];

	always @(posedge clk) begin
		if (resultValid)
			checkIdx <= checkIdx + 1;
	end

	dataCheck: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |-> resultData == expData)
		else begin
			valueErrors++;
			$display("ERROR %0t resultData expected %h observed %h", $time,
				$sampled(expData), $sampled(resultData));
		end

	flagsCheck: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |-> resultFlags == expFlags)
		else begin
			valueErrors++;
			$display("ERROR %0t resultFlags expected %b observed %b", $time,
				$sampled(expFlags), $sampled(resultFlags));
		end

	beatOutstanding: assert property (@(posedge clk) disable iff (!rstN)
		resultValid |-> checkIdx < sendIdx)
		else begin
			valueErrors++;
			$display("result beat arrived with no instruction outstanding at %0t", $time);
		end

	// consumer returns one credit per beat, except during pauses.
	initial begin
		int owed;
		int cycle;
		owed = 0;
		cycle = 0;
		@(posedge rstN);
		forever begin
			@(posedge clk);
			cycle++;
			if (resultValid)
				owed++;
			if ((cycle % 40) < 40 - holdCycles && owed > 0) begin
				resultCredit <= 1'b1;
				owed--;
			end else begin
				resultCredit <= 1'b0;
			end
		end
	end

	initial begin
		#(numInst * (queueDepth + holdCycles + 10) * clkPeriod);
		$display("timeout, only %0d of %0d results arrived", checkIdx, numInst);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		int credits;
		logic [dataWidth-1:0] d;
		logic [flagWidth-1:0] f;
		seed = 32'h9faaa9de;
		rstN = 1'b0;
		instValid = 1'b0;
		instData = '0;
		resultCredit = 1'b0;
		modelFlags = '0;
		for (int r = 0; r < 16; r++)
			modelRegs[r] = '0;
		buildProgram();
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		credits = queueDepth;
		while (sendIdx < numInst) begin
			@(posedge clk);
			if (instCredit)
				credits++;
			if (credits > 0) begin
				instValid <= 1'b1;
				instData <= instList[sendIdx];
				modelIssue(instList[sendIdx], d, f);
				expDataArr[sendIdx] = d;
				expFlagsArr[sendIdx] = f;
				sendIdx++;
				credits--;
			end else begin
				instValid <= 1'b0;
			end
		end
		@(posedge clk);
		instValid <= 1'b0;
		wait (checkIdx == numInst);
		repeat (5) @(posedge clk); // room for a stray extra beat.
		protocolErrors = DUT.protocolCheck.failCount;
		$display("checks failed: value %0d, protocol %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* cr16Datapath.f */
hw/cr16Pkg.sv
hw/instQueue.sv
hw/registerFile.sv
hw/alu.sv
hw/issueControl.sv
hw/cr16Datapath.sv
verification/cr16Datapath_assertions.sv
verification/cr16DatapathTb.sv
